//--- hw/cgmii_block_builder.sv
`timescale 1ns/100ps
module cgmii_block_builder (
	input  logic                              i_clock,
	input  logic                              i_reset,
	input  logic                              i_enable,
	input  cgmii_gen_pkg::state_t             i_state,
	input  logic [cgmii_gen_pkg::DATA_W-1:0]  i_payload,
	output logic                              o_advance,
	output cgmii_gen_pkg::gen_out_t           o_out,
	output logic                              o_valid
);

	cgmii_gen_pkg::cgmii_blk_t  blk_nxt;
	cgmii_gen_pkg::cgmii_blk_t  blk_q;
	cgmii_gen_pkg::state_t      state_q;
	logic                       sof_q;
	logic                       valid_q;

	// Lane 0 is the low byte
	always_comb begin
		case (i_state)
			cgmii_gen_pkg::ST_INIT,
			cgmii_gen_pkg::ST_IDLE: begin
				blk_nxt.data = {8{cgmii_gen_pkg::CH_IDLE}};
				blk_nxt.ctrl = 8'hff;
			end
			cgmii_gen_pkg::ST_START: begin
				blk_nxt.data = {cgmii_gen_pkg::CH_SFD, {6{cgmii_gen_pkg::CH_PREAMBLE}},
					cgmii_gen_pkg::CH_START};
				blk_nxt.ctrl = 8'h01;
			end
			cgmii_gen_pkg::ST_DATA: begin
				blk_nxt.data = i_payload;
				blk_nxt.ctrl = 8'h00;
			end
			cgmii_gen_pkg::ST_TERM: begin
				blk_nxt.data = {{7{cgmii_gen_pkg::CH_IDLE}}, cgmii_gen_pkg::CH_TERM};
				blk_nxt.ctrl = 8'hff; // Terminate always in lane 0
			end
			default: begin
				blk_nxt.data = {8{cgmii_gen_pkg::CH_ERROR}};
				blk_nxt.ctrl = 8'hff;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_enable) begin
			blk_q <= blk_nxt;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			sof_q   <= 1'b0;
			state_q <= cgmii_gen_pkg::ST_INIT;
			valid_q <= 1'b0;
		end else begin
			valid_q <= i_enable; // One-cycle strobe per step
			if (i_enable) begin
				sof_q   <= (i_state == cgmii_gen_pkg::ST_START);
				state_q <= i_state;
			end
		end
	end

	assign o_advance = i_enable && (i_state == cgmii_gen_pkg::ST_DATA);
	assign o_out     = '{blk: blk_q, sof: sof_q, state: state_q};
	assign o_valid   = valid_q;

endmodule

//--- hw/cgmii_frame_gen.sv
`timescale 1ns/100ps
module cgmii_frame_gen (
	input  logic                             i_clock,
	input  logic                             i_reset,
	input  logic                             i_enable,
	input  cgmii_gen_pkg::dbg_cmd_t          i_dbg,
	input  logic [cgmii_gen_pkg::CNT_W-1:0]  i_n_idle,
	input  logic [cgmii_gen_pkg::CNT_W-1:0]  i_n_data,
	output cgmii_gen_pkg::gen_out_t          o_out,
	output logic                             o_valid
);

	cgmii_gen_pkg::state_t              state;
	cgmii_gen_pkg::timer_ctl_t          timer_ctl;
	logic [cgmii_gen_pkg::CNT_W-1:0]    limit;
	logic                               done;
	logic                               advance;
	logic [cgmii_gen_pkg::DATA_W-1:0]   payload;

	frame_fsm u_fsm (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_enable    (i_enable),
		.i_dbg       (i_dbg),
		.i_n_idle    (i_n_idle),
		.i_n_data    (i_n_data),
		.i_done      (done),
		.o_state     (state),
		.o_timer_ctl (timer_ctl),
		.o_limit     (limit)
	);

	length_timer u_timer (
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.i_enable (i_enable),
		.i_ctl    (timer_ctl),
		.i_limit  (limit),
		.o_done   (done)
	);

	payload_prbs u_prbs (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_advance (advance), // Already qualified by i_enable
		.o_word    (payload)
	);

	cgmii_block_builder u_builder (
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_enable  (i_enable),
		.i_state   (state),
		.i_payload (payload),
		.o_advance (advance),
		.o_out     (o_out),
		.o_valid   (o_valid)
	);

endmodule

//--- hw/cgmii_gen_pkg.sv
package cgmii_gen_pkg;

	localparam int DATA_W = 64;
	localparam int CTRL_W = 8;
	localparam int CNT_W  = 8;

	// CGMII control characters
	localparam logic [7:0] CH_IDLE     = 8'h07;
	localparam logic [7:0] CH_START    = 8'hfb;
	localparam logic [7:0] CH_TERM     = 8'hfd;
	localparam logic [7:0] CH_ERROR    = 8'hfe;
	localparam logic [7:0] CH_PREAMBLE = 8'h55;
	localparam logic [7:0] CH_SFD      = 8'hd5;

	localparam logic [31:0] PAYLOAD_SEED = 32'h1d2c3b4a; // Nonzero xorshift seed

	typedef enum logic [5:0] {
		ST_INIT  = 6'b000001,
		ST_IDLE  = 6'b000010,
		ST_START = 6'b000100,
		ST_DATA  = 6'b001000,
		ST_TERM  = 6'b010000,
		ST_ERROR = 6'b100000
	} state_t;

	typedef enum logic [3:0] {
		DBG_NONE          = 4'h0,
		DBG_FORCE_ERROR   = 4'h1,
		DBG_FORCE_IDLE    = 4'h2,
		DBG_FORCE_DATA    = 4'h4,
		DBG_RESTART_COUNT = 4'h8,
		DBG_FORCE_TERM    = 4'hf
	} dbg_cmd_t;

	// clear and step together load the count with 1
	typedef struct packed {
		logic clear;
		logic step;
		logic sel_data;
	} timer_ctl_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [CTRL_W-1:0] ctrl;
	} cgmii_blk_t;

	typedef struct packed {
		cgmii_blk_t blk;
		logic       sof;
		state_t     state;
	} gen_out_t;

endpackage

//--- hw/frame_fsm.sv
`timescale 1ns/100ps
module frame_fsm (
	input  logic                             i_clock,
	input  logic                             i_reset,
	input  logic                             i_enable,
	input  cgmii_gen_pkg::dbg_cmd_t          i_dbg,
	input  logic [cgmii_gen_pkg::CNT_W-1:0]  i_n_idle,
	input  logic [cgmii_gen_pkg::CNT_W-1:0]  i_n_data,
	input  logic                             i_done,
	output cgmii_gen_pkg::state_t            o_state,
	output cgmii_gen_pkg::timer_ctl_t        o_timer_ctl,
	output logic [cgmii_gen_pkg::CNT_W-1:0]  o_limit
);

	cgmii_gen_pkg::state_t              state;
	cgmii_gen_pkg::state_t              state_nxt;
	cgmii_gen_pkg::timer_ctl_t          ctl;
	logic [cgmii_gen_pkg::CNT_W-1:0]    n_idle;
	logic [cgmii_gen_pkg::CNT_W-1:0]    n_data;
	logic                               load_len;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state  <= cgmii_gen_pkg::ST_INIT;
			n_idle <= i_n_idle; // Lengths follow the inputs during reset
			n_data <= i_n_data;
		end else if (i_enable) begin
			state <= state_nxt;
			if (load_len) begin
				n_idle <= i_n_idle;
				n_data <= i_n_data;
			end
		end
	end

	always_comb begin
		state_nxt    = state;
		ctl          = '0;
		ctl.sel_data = (state == cgmii_gen_pkg::ST_DATA);
		load_len     = 1'b0;
		case (i_dbg)
			cgmii_gen_pkg::DBG_NONE: begin
				case (state)
					cgmii_gen_pkg::ST_INIT: begin
						state_nxt = cgmii_gen_pkg::ST_IDLE;
						ctl.clear = 1'b1;
					end
					cgmii_gen_pkg::ST_IDLE: begin
						if (i_done) begin
							state_nxt = cgmii_gen_pkg::ST_START;
							ctl.clear = 1'b1;
						end else begin
							ctl.step = 1'b1;
						end
					end
					cgmii_gen_pkg::ST_START: begin
						state_nxt = cgmii_gen_pkg::ST_DATA;
						ctl.clear = 1'b1;
					end
					cgmii_gen_pkg::ST_DATA: begin
						if (i_done) begin
							state_nxt = cgmii_gen_pkg::ST_TERM;
							ctl.clear = 1'b1;
						end else begin
							ctl.step = 1'b1;
						end
					end
					cgmii_gen_pkg::ST_TERM: begin
						state_nxt = cgmii_gen_pkg::ST_IDLE;
						ctl.clear = 1'b1;
						load_len  = 1'b1; // New lengths for the next frame
					end
					cgmii_gen_pkg::ST_ERROR: begin
						state_nxt = cgmii_gen_pkg::ST_IDLE;
						ctl.clear = 1'b1;
					end
					default: begin
						state_nxt = cgmii_gen_pkg::ST_ERROR;
						ctl.clear = 1'b1;
					end
				endcase
			end
			// Timer is shared, so every forced jump starts its phase from zero
			cgmii_gen_pkg::DBG_FORCE_ERROR: begin
				state_nxt = cgmii_gen_pkg::ST_ERROR;
				ctl.clear = 1'b1;
			end
			cgmii_gen_pkg::DBG_FORCE_IDLE: begin
				state_nxt = cgmii_gen_pkg::ST_IDLE;
				ctl.clear = 1'b1;
			end
			cgmii_gen_pkg::DBG_FORCE_DATA: begin
				state_nxt = cgmii_gen_pkg::ST_DATA;
				ctl.clear = 1'b1;
			end
			cgmii_gen_pkg::DBG_FORCE_TERM: begin
				state_nxt = cgmii_gen_pkg::ST_TERM;
				ctl.clear = 1'b1;
			end
			cgmii_gen_pkg::DBG_RESTART_COUNT: begin
				ctl.clear = 1'b1; // Count back to 1
				ctl.step  = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign o_state     = state;
	assign o_timer_ctl = ctl;
	assign o_limit     = ctl.sel_data ? n_data : n_idle;

	a_state_onehot: assert property (@(posedge i_clock) disable iff (i_reset)
		$onehot(state))
		else $error("frame state not one-hot: %b", state);

endmodule

//--- hw/length_timer.sv
`timescale 1ns/100ps
module length_timer (
	input  logic                             i_clock,
	input  logic                             i_reset,
	input  logic                             i_enable,
	input  cgmii_gen_pkg::timer_ctl_t        i_ctl,
	input  logic [cgmii_gen_pkg::CNT_W-1:0]  i_limit,
	output logic                             o_done
);

	logic [cgmii_gen_pkg::CNT_W-1:0] count;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			count <= '0;
		end else if (i_enable) begin
			if (i_ctl.clear) begin
				count <= {{(cgmii_gen_pkg::CNT_W-1){1'b0}}, i_ctl.step}; // 0, or 1 on restart
			end else if (i_ctl.step) begin
				count <= count + 1'b1;
			end
		end
	end

	assign o_done = (count == i_limit);

	// FSM only steps while the phase is unfinished
	a_count_in_range: assert property (@(posedge i_clock) disable iff (i_reset)
		i_enable && i_ctl.step && !i_ctl.clear |-> count < i_limit)
		else $error("timer stepping past limit: count %0d limit %0d", count, i_limit);

endmodule

//--- hw/payload_prbs.sv
`timescale 1ns/100ps
module payload_prbs (
	input  logic                              i_clock,
	input  logic                              i_reset,
	input  logic                              i_advance,
	output logic [cgmii_gen_pkg::DATA_W-1:0]  o_word
);

	logic [31:0] s;
	logic [31:0] s_a;
	logic [31:0] s_b;
	logic [31:0] s_nxt;

	// xorshift32, shifts 13, 17, 5
	always_comb begin
		s_a   = s ^ (s << 13);
		s_b   = s_a ^ (s_a >> 17);
		s_nxt = s_b ^ (s_b << 5);
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			s <= cgmii_gen_pkg::PAYLOAD_SEED;
		end else if (i_advance) begin
			s <= s_nxt;
		end
	end

	assign o_word = {s, ~s}; // Inverse in the low half

	a_state_nonzero: assert property (@(posedge i_clock) disable iff (i_reset)
		s != 32'h0)
		else $error("payload generator locked at zero");

endmodule

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

top=cgmii_frame_gen_tb
log=sim.log

verilator --binary --assert --timescale 1ns/100ps -j 0 \
	--top-module "$top" -f sources.f -o "V$top"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./obj_dir/V$top" > "$log" 2>&1
status=$?
cat "$log"

if grep -q "SIMULATION FAILED" "$log"; then
	echo "Failure reported in $log"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

echo "No failure found in $log"
exit 0

//--- sources.f
+incdir+verif
hw/cgmii_gen_pkg.sv
hw/frame_fsm.sv
hw/length_timer.sv
hw/payload_prbs.sv
hw/cgmii_block_builder.sv
hw/cgmii_frame_gen.sv
verif/cgmii_frame_gen_tb.sv

//--- verif/cgmii_frame_gen_tb_table.svh
`ifndef CGMII_FRAME_GEN_TB_TABLE_SVH
`define CGMII_FRAME_GEN_TB_TABLE_SVH

// Columns: n_idle, n_data, debug command, step of the command in the row, steps in the row
// The command is applied on one enabled step only; all other steps use DBG_NONE
typedef struct packed {
	logic [cgmii_gen_pkg::CNT_W-1:0] n_idle;
	logic [cgmii_gen_pkg::CNT_W-1:0] n_data;
	logic [3:0]                      dbg;
	int                              dbg_step;
	int                              steps;
} stim_row_t;

localparam int NUM_ROWS = 12;

function automatic stim_row_t stimulus_row(input int idx);
	stim_row_t row;
	case (idx)
		0:  row = '{8'd2,  8'd3,  cgmii_gen_pkg::DBG_NONE,          0, 30};
		1:  row = '{8'd1,  8'd5,  cgmii_gen_pkg::DBG_NONE,          0, 20}; // Mid-frame change
		2:  row = '{8'd0,  8'd0,  cgmii_gen_pkg::DBG_NONE,          0, 12};
		3:  row = '{8'd3,  8'd4,  cgmii_gen_pkg::DBG_FORCE_ERROR,   5, 24};
		4:  row = '{8'd3,  8'd4,  cgmii_gen_pkg::DBG_FORCE_TERM,    7, 16};
		5:  row = '{8'd2,  8'd6,  cgmii_gen_pkg::DBG_FORCE_IDLE,    9, 18};
		6:  row = '{8'd2,  8'd6,  4'h3,                             4, 14}; // Undefined code
		7:  row = '{8'd1,  8'd10, cgmii_gen_pkg::DBG_NONE,          0, 30};
		8:  row = '{8'd1,  8'd10, cgmii_gen_pkg::DBG_FORCE_DATA,    0, 6};
		9:  row = '{8'd1,  8'd10, cgmii_gen_pkg::DBG_RESTART_COUNT, 2, 30}; // Inside data run
		10: row = '{8'd2,  8'd2,  cgmii_gen_pkg::DBG_RESTART_COUNT, 5, 20};
		11: row = '{8'd4,  8'd1,  cgmii_gen_pkg::DBG_NONE,          0, 24};
		default: row = '0;
	endcase
	return row;
endfunction

`endif

//--- verif/cgmii_frame_gen_tb.sv
`timescale 1ns/100ps
module cgmii_frame_gen_tb;

	localparam int RESET_CYCLES = 16;
	localparam int MAX_GAP      = 3; // Idle clocks allowed between enables
	localparam int MARGIN       = 100;

	logic                            clock;
	logic                            reset;
	logic                            enable;
	cgmii_gen_pkg::dbg_cmd_t         dbg;
	logic [cgmii_gen_pkg::CNT_W-1:0] n_idle;
	logic [cgmii_gen_pkg::CNT_W-1:0] n_data;
	cgmii_gen_pkg::gen_out_t         out;
	logic                            valid;

	cgmii_gen_pkg::state_t           m_state; // Reference model
	int                              m_count;
	logic [cgmii_gen_pkg::CNT_W-1:0] m_idle;
	logic [cgmii_gen_pkg::CNT_W-1:0] m_data;
	logic [31:0]                     m_payload;
	logic [cgmii_gen_pkg::CNT_W-1:0] cur_n_idle;
	logic [cgmii_gen_pkg::CNT_W-1:0] cur_n_data;
	logic                            exp_pending; // Block owed for the last enable
	cgmii_gen_pkg::cgmii_blk_t       exp_blk;
	logic                            exp_sof;
	cgmii_gen_pkg::state_t           exp_state;
	logic [31:0]                     rng;
	int                              error_count;

	`include "cgmii_frame_gen_tb_table.svh"

	cgmii_frame_gen i_dut (
		.i_clock  (clock),
		.i_reset  (reset),
		.i_enable (enable),
		.i_dbg    (dbg),
		.i_n_idle (n_idle),
		.i_n_data (n_data),
		.o_out    (out),
		.o_valid  (valid)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic int total_steps();
		stim_row_t row;
		int        sum;
		int        r;
		sum = 0;
		for (r = 0; r < NUM_ROWS; r++) begin
			row = stimulus_row(r);
			sum += row.steps;
		end
		return sum;
	endfunction

	function automatic cgmii_gen_pkg::cgmii_blk_t expected_block(
		input cgmii_gen_pkg::state_t st,
		input logic [31:0]           s
	);
		cgmii_gen_pkg::cgmii_blk_t b;
		b.data = {8{cgmii_gen_pkg::CH_IDLE}};
		b.ctrl = 8'hff;
		case (st)
			cgmii_gen_pkg::ST_START: begin
				b.data[7:0]   = cgmii_gen_pkg::CH_START;
				b.data[55:8]  = {6{cgmii_gen_pkg::CH_PREAMBLE}};
				b.data[63:56] = cgmii_gen_pkg::CH_SFD;
				b.ctrl        = 8'h01;
			end
			cgmii_gen_pkg::ST_DATA: begin
				b.data = {s, ~s};
				b.ctrl = 8'h00;
			end
			cgmii_gen_pkg::ST_TERM:  b.data[7:0] = cgmii_gen_pkg::CH_TERM;
			cgmii_gen_pkg::ST_ERROR: b.data = {8{cgmii_gen_pkg::CH_ERROR}};
			default: begin
			end
		endcase
		return b;
	endfunction

	task automatic stop_with_failure();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			error_count++;
			$display("[FAIL] %0t ns %s got %h expected %h", $time, name, got, exp);
			stop_with_failure();
		end
	endtask

	task automatic enter_state(input cgmii_gen_pkg::state_t st);
		m_state = st;
		m_count = 0; // Each phase counts from zero
	endtask

	// Normal sequencing, one enabled step
	task automatic follow_sequence();
		case (m_state)
			cgmii_gen_pkg::ST_INIT:  enter_state(cgmii_gen_pkg::ST_IDLE);
			cgmii_gen_pkg::ST_IDLE: begin
				if (m_count == int'(m_idle)) enter_state(cgmii_gen_pkg::ST_START);
				else m_count++;
			end
			cgmii_gen_pkg::ST_START: enter_state(cgmii_gen_pkg::ST_DATA);
			cgmii_gen_pkg::ST_DATA: begin
				if (m_count == int'(m_data)) enter_state(cgmii_gen_pkg::ST_TERM);
				else m_count++;
			end
			cgmii_gen_pkg::ST_TERM: begin
				enter_state(cgmii_gen_pkg::ST_IDLE);
				m_idle = cur_n_idle; // Lengths for the next frame
				m_data = cur_n_data;
			end
			cgmii_gen_pkg::ST_ERROR: enter_state(cgmii_gen_pkg::ST_IDLE);
			default: enter_state(cgmii_gen_pkg::ST_ERROR);
		endcase
	endtask

	task automatic advance_model(input cgmii_gen_pkg::dbg_cmd_t cmd);
		case (cmd)
			cgmii_gen_pkg::DBG_NONE:          follow_sequence();
			cgmii_gen_pkg::DBG_FORCE_ERROR:   enter_state(cgmii_gen_pkg::ST_ERROR);
			cgmii_gen_pkg::DBG_FORCE_IDLE:    enter_state(cgmii_gen_pkg::ST_IDLE);
			cgmii_gen_pkg::DBG_FORCE_DATA:    enter_state(cgmii_gen_pkg::ST_DATA);
			cgmii_gen_pkg::DBG_FORCE_TERM:    enter_state(cgmii_gen_pkg::ST_TERM);
			cgmii_gen_pkg::DBG_RESTART_COUNT: m_count = 1;
			default: begin
			end
		endcase
	endtask

	// One clock: drive on the rising edge, check the previous step at the falling edge
	task automatic drive_cycle(input logic en, input cgmii_gen_pkg::dbg_cmd_t cmd);
		@(posedge clock);
		enable <= en;
		dbg    <= cmd;
		n_idle <= cur_n_idle;
		n_data <= cur_n_data;
		@(negedge clock);
		check_value("o_valid", 64'(valid), 64'(exp_pending));
		if (exp_pending) begin
			check_value("o_out.blk.data", out.blk.data, exp_blk.data);
			check_value("o_out.blk.ctrl", 64'(out.blk.ctrl), 64'(exp_blk.ctrl));
			check_value("o_out.sof", 64'(out.sof), 64'(exp_sof));
			check_value("o_out.state", 64'(out.state), 64'(exp_state));
		end
		exp_pending = en;
		if (en) begin
			exp_blk   = expected_block(m_state, m_payload);
			exp_sof   = (m_state == cgmii_gen_pkg::ST_START);
			exp_state = m_state;
			if (m_state == cgmii_gen_pkg::ST_DATA) m_payload = xorshift32(m_payload);
			advance_model(cmd);
		end
	endtask

	initial begin : watchdog
		int cycles;
		int limit;
		cycles = 0;
		limit  = total_steps() * (MAX_GAP + 1) + RESET_CYCLES + MARGIN;
		while (cycles < limit) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: the test did not finish within %0d clock cycles", limit);
		stop_with_failure();
	end

	initial begin : stimulus
		stim_row_t               row;
		cgmii_gen_pkg::dbg_cmd_t cmd;
		int                      r;
		int                      st;
		int                      gap;
		row         = stimulus_row(0);
		cur_n_idle  = row.n_idle; // Loaded by the DUT during reset
		cur_n_data  = row.n_data;
		reset       <= 1'b1;
		enable      <= 1'b0;
		dbg         <= cgmii_gen_pkg::DBG_NONE;
		n_idle      <= cur_n_idle;
		n_data      <= cur_n_data;
		m_state     = cgmii_gen_pkg::ST_INIT;
		m_count     = 0;
		m_idle      = cur_n_idle;
		m_data      = cur_n_data;
		m_payload   = cgmii_gen_pkg::PAYLOAD_SEED;
		exp_pending = 1'b0;
		rng         = 32'hbda4;
		error_count = 0;
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		check_value("o_valid", 64'(valid), 64'd0);
		check_value("o_out.sof", 64'(out.sof), 64'd0);
		check_value("o_out.state", 64'(out.state), 64'(cgmii_gen_pkg::ST_INIT));
		for (r = 0; r < NUM_ROWS; r++) begin
			row        = stimulus_row(r);
			cur_n_idle = row.n_idle;
			cur_n_data = row.n_data;
			for (st = 0; st < row.steps; st++) begin
				rng = xorshift32(rng);
				gap = int'(rng % 32'(MAX_GAP + 1));
				repeat (gap) drive_cycle(1'b0, cgmii_gen_pkg::DBG_NONE);
				cmd = (st == row.dbg_step) ? cgmii_gen_pkg::dbg_cmd_t'(row.dbg)
					: cgmii_gen_pkg::DBG_NONE;
				drive_cycle(1'b1, cmd);
			end
		end
		drive_cycle(1'b0, cgmii_gen_pkg::DBG_NONE); // Collect the last block
		if (error_count == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			stop_with_failure();
		end
	end

endmodule
